/* serdes_test_cfg.svh */
`ifndef SERDES_TEST_CFG_SVH
`define SERDES_TEST_CFG_SVH

`define SERDES_DATA_WIDTH   8     // bits per link word, sent MSB first
`define SERDES_PRBS_LEN     7     // lfsr length for x^7+x^6+1, no wider than a word
`define SERDES_LOCK_WORDS   4     // matching words in a row before the checker locks

// register byte addresses on the 4-bit axi4-lite address bus
`define SERDES_ADDR_CTRL    4'h0  // bit 0 enable, bit 1 clear counters
`define SERDES_ADDR_STATUS  4'h4  // bit 0 locked, bits 31..16 slip count
`define SERDES_ADDR_ERRCNT  4'h8  // bit errors seen while locked
`define SERDES_ADDR_WORDCNT 4'hC  // words checked while locked

`endif

/* serdes_test_pkg.sv */
`include "serdes_test_cfg.svh"

package serdes_test_pkg;

    typedef logic [`SERDES_DATA_WIDTH-1:0] data_word_t;  // one word on the link

    typedef enum logic [1:0] {
        SEED,    // waiting for a word to load the lfsr from
        VERIFY,  // counting matches before lock
        LOCKED   // counting errors
    } chk_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // runs the lfsr one step per word bit, the first bit out lands in the msb
    function automatic data_word_t prbs_next_word(
        input  logic [`SERDES_PRBS_LEN-1:0] state,
        output logic [`SERDES_PRBS_LEN-1:0] next_state
    );
        logic [`SERDES_PRBS_LEN-1:0] s;
        logic                        fb;
        data_word_t                  word;
        s = state;
        for (int i = `SERDES_DATA_WIDTH - 1; i >= 0; i--) begin
            fb      = s[`SERDES_PRBS_LEN-1] ^ s[`SERDES_PRBS_LEN-2];  // taps 7 and 6
            word[i] = fb;                                            // output bit is the new bit
            s       = {s[`SERDES_PRBS_LEN-2:0], fb};
        end
        next_state = s;  // equals the low PRBS_LEN bits of the word just made
        return word;
    endfunction

endpackage

/* prbs_gen.sv */
`timescale 1ns/10ps
`include "serdes_test_cfg.svh"

module prbs_gen import serdes_test_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  logic       word_tick,  // serializer takes tx_word in this cycle
    input  logic       enable,
    output data_word_t tx_word
);

    logic [`SERDES_PRBS_LEN-1:0] lfsr;       // sequence state between words
    logic [`SERDES_PRBS_LEN-1:0] lfsr_next;  // state after the word on tx_word
    data_word_t                  word_next;

    always_comb begin
        word_next = prbs_next_word(lfsr, lfsr_next);  // next word is always ready
    end

    // zero words while disabled so the line goes quiet from the next word on
    assign tx_word = enable ? word_next : '0;

    always_ff @(posedge CLK) begin
        if (rst) begin
            lfsr <= '1;  // all ones, a legal nonzero state
        end else if (word_tick && enable) begin
            lfsr <= lfsr_next;  // advance only when a word really goes out
        end
    end

endmodule

/* word_serializer.sv */
`timescale 1ns/10ps
`include "serdes_test_cfg.svh"

module word_serializer import serdes_test_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  data_word_t tx_word,
    output logic       word_tick,  // one cycle high per word
    output logic       ser_out
);

    localparam int CNT_W = $clog2(`SERDES_DATA_WIDTH);

    logic [CNT_W-1:0] bit_cnt;  // position within the outgoing word
    data_word_t       shreg;    // bits of the current word still to send

    // the strobe marks the last bit slot of a word, the load happens on that edge
    assign word_tick = (bit_cnt == CNT_W'(`SERDES_DATA_WIDTH - 1));

    always_ff @(posedge CLK) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (word_tick) begin
            bit_cnt <= '0;  // wrap explicitly in case the width is not a power of two
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            shreg <= '0;  // line stays low until the first word is loaded
        end else if (word_tick) begin
            shreg <= tx_word << 1;  // msb leaves straight away through ser_out
        end else begin
            shreg <= shreg << 1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            ser_out <= 1'b0;
        end else begin
            ser_out <= word_tick ? tx_word[`SERDES_DATA_WIDTH-1] : shreg[`SERDES_DATA_WIDTH-1];
        end
    end

endmodule

/* word_deserializer.sv */
`timescale 1ns/10ps
`include "serdes_test_cfg.svh"

module word_deserializer import serdes_test_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  logic       ser_in,
    input  logic       slip,      // move the word boundary by one bit
    output data_word_t rx_word,
    output logic       rx_valid   // one cycle high per assembled word
);

    localparam int CNT_W = $clog2(`SERDES_DATA_WIDTH);

    logic [CNT_W-1:0] bit_cnt;  // bits gathered in the current word
    data_word_t       shreg;    // newest bit in the lsb
    logic             wrap;     // last bit of a word arrives this cycle

    // a slip holds the counter so the current word takes one extra bit
    assign wrap = (bit_cnt == CNT_W'(`SERDES_DATA_WIDTH - 1)) && !slip;

    always_ff @(posedge CLK) begin
        shreg <= {shreg[`SERDES_DATA_WIDTH-2:0], ser_in};  // shifts every cycle, slip or not
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (wrap) begin
            bit_cnt <= '0;
        end else if (!slip) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (wrap) begin
            rx_word <= {shreg[`SERDES_DATA_WIDTH-2:0], ser_in};  // first bit received is the msb
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= wrap;
        end
    end

endmodule

/* prbs_checker.sv */
`timescale 1ns/10ps
`include "serdes_test_cfg.svh"

module prbs_checker import serdes_test_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  data_word_t  rx_word,
    input  logic        rx_valid,
    input  logic        clear,       // zeroes the counters and the error flag
    output logic        slip,        // one cycle request to the deserializer
    output logic        locked,
    output logic        error,       // sticky, any bit error while locked
    output logic [31:0] err_count,
    output logic [31:0] word_count,
    output logic [15:0] slip_count
);

    localparam int MATCH_W = $clog2(`SERDES_LOCK_WORDS);

    chk_state_e                  state;
    logic [`SERDES_PRBS_LEN-1:0] lfsr;       // predicts the next received word
    logic [`SERDES_PRBS_LEN-1:0] lfsr_next;
    data_word_t                  pred;       // expected word
    data_word_t                  mismatch;   // one bit set per wrong bit
    logic [31:0]                 bad_bits;   // popcount of the mismatch
    logic [MATCH_W-1:0]          match_cnt;  // good words in a row during VERIFY
    logic [2:0]                  bad_cnt;    // wrong words in a row while locked

    always_comb begin
        pred = prbs_next_word(lfsr, lfsr_next);
    end

    assign mismatch = rx_word ^ pred;
    assign bad_bits = 32'($countones(mismatch));

    always_ff @(posedge CLK) begin
        slip <= 1'b0;  // pulse only, set below on a failed verify
        if (rst) begin
            state      <= SEED;
            locked     <= 1'b0;
            error      <= 1'b0;
            err_count  <= '0;
            word_count <= '0;
            slip_count <= '0;
            match_cnt  <= '0;
            bad_cnt    <= '0;
        end else begin
            if (rx_valid) begin
                case (state)
                    SEED: begin
                        // a zero seed would lock onto an idle line, so wait for real data
                        if (rx_word[`SERDES_PRBS_LEN-1:0] != '0) begin
                            lfsr      <= rx_word[`SERDES_PRBS_LEN-1:0];
                            match_cnt <= '0;
                            state     <= VERIFY;
                        end
                    end
                    VERIFY: begin
                        if (mismatch == '0) begin
                            lfsr <= lfsr_next;  // free run from here, no reseeding
                            if (match_cnt == MATCH_W'(`SERDES_LOCK_WORDS - 1)) begin
                                state   <= LOCKED;
                                locked  <= 1'b1;
                                bad_cnt <= '0;
                            end else begin
                                match_cnt <= match_cnt + 1'b1;
                            end
                        end else begin
                            slip       <= 1'b1;  // try the next bit boundary
                            slip_count <= slip_count + 1'b1;
                            state      <= SEED;
                        end
                    end
                    default: begin
                        lfsr       <= lfsr_next;  // errors stay single, they do not spread
                        err_count  <= err_count + bad_bits;
                        word_count <= word_count + 1'b1;
                        if (mismatch != '0) begin
                            error   <= 1'b1;
                            bad_cnt <= bad_cnt + 1'b1;
                            if (bad_cnt == 3'd7) begin
                                state  <= SEED;  // eighth wrong word in a row, lock lost
                                locked <= 1'b0;
                            end
                        end else begin
                            bad_cnt <= '0;
                        end
                    end
                endcase
            end
            if (clear) begin
                error      <= 1'b0;  // clear wins over a count in the same cycle
                err_count  <= '0;
                word_count <= '0;
                slip_count <= '0;
            end
        end
    end

endmodule

/* axil_regs.sv */
`timescale 1ns/10ps
`include "serdes_test_cfg.svh"

module axil_regs import serdes_test_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic [3:0]  s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [3:0]  s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready,
    input  logic        locked,
    input  logic [31:0] err_count,
    input  logic [31:0] word_count,
    input  logic [15:0] slip_count,
    output logic        enable,
    output logic        clear_pulse
);

    logic        wr_go;    // both write channels present and no response held
    logic        wr_hs;    // write handshake in this cycle
    logic        wr_ctrl;  // that handshake writes byte 0 of CTRL
    axil_resp_e  wr_resp;
    axil_resp_e  bresp_q;
    logic        ar_go;
    logic        ar_hs;
    logic [31:0] rd_data;
    axil_resp_e  rd_resp;
    axil_resp_e  rresp_q;

    assign wr_go   = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !s_axil_awready;
    assign wr_hs   = s_axil_awready && s_axil_awvalid && s_axil_wvalid;
    assign wr_ctrl = wr_hs && (s_axil_awaddr == `SERDES_ADDR_CTRL) && s_axil_wstrb[0];
    assign ar_go   = s_axil_arvalid && !s_axil_rvalid && !s_axil_arready;
    assign ar_hs   = s_axil_arready && s_axil_arvalid;

    always_comb begin
        case (s_axil_awaddr)
            `SERDES_ADDR_CTRL, `SERDES_ADDR_STATUS,
            `SERDES_ADDR_ERRCNT, `SERDES_ADDR_WORDCNT: wr_resp = OKAY;  // read-only ones ignore data
            default:                                   wr_resp = SLVERR;
        endcase
    end

    always_comb begin
        rd_data = '0;  // unmapped reads return zero
        rd_resp = OKAY;
        case (s_axil_araddr)
            `SERDES_ADDR_CTRL:    rd_data = {31'b0, enable};  // clear bit always reads 0
            `SERDES_ADDR_STATUS:  rd_data = {slip_count, 15'b0, locked};
            `SERDES_ADDR_ERRCNT:  rd_data = err_count;
            `SERDES_ADDR_WORDCNT: rd_data = word_count;
            default:              rd_resp = SLVERR;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            enable         <= 1'b0;
            clear_pulse    <= 1'b0;
        end else begin
            s_axil_awready <= wr_go;  // ready for one cycle, both channels together
            s_axil_wready  <= wr_go;
            clear_pulse    <= wr_ctrl && s_axil_wdata[1];
            if (wr_ctrl) begin
                enable <= s_axil_wdata[0];
            end
            if (wr_hs) begin
                s_axil_bvalid <= 1'b1;  // response in the same cycle the write lands
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_hs) begin
            bresp_q <= wr_resp;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
        end else begin
            s_axil_arready <= ar_go;  // held low while a read response waits
            if (ar_hs) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (ar_hs) begin
            s_axil_rdata <= rd_data;  // sampled at the handshake, stable while held
            rresp_q      <= rd_resp;
        end
    end

    assign s_axil_bresp = bresp_q;
    assign s_axil_rresp = rresp_q;

endmodule

/* serdes_test_top.sv */
`timescale 1ns/10ps

module serdes_test_top import serdes_test_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    output logic        ser_out,
    input  logic        ser_in,
    output logic        error,
    input  logic [3:0]  s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [3:0]  s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready
);

    logic        word_tick;    // word strobe from the serializer bit counter
    data_word_t  tx_word;
    data_word_t  rx_word;
    logic        rx_valid;
    logic        slip;
    logic        locked;
    logic [31:0] err_count;
    logic [31:0] word_count;
    logic [15:0] slip_count;
    logic        enable;
    logic        clear_pulse;

    prbs_gen u_prbs_gen (
        .CLK       (CLK),
        .rst       (rst),
        .word_tick (word_tick),
        .enable    (enable),
        .tx_word   (tx_word)
    );

    word_serializer u_word_serializer (
        .CLK       (CLK),
        .rst       (rst),
        .tx_word   (tx_word),
        .word_tick (word_tick),
        .ser_out   (ser_out)
    );

    word_deserializer u_word_deserializer (
        .CLK      (CLK),
        .rst      (rst),
        .ser_in   (ser_in),
        .slip     (slip),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    prbs_checker u_prbs_checker (
        .CLK        (CLK),
        .rst        (rst),
        .rx_word    (rx_word),
        .rx_valid   (rx_valid),
        .clear      (clear_pulse),
        .slip       (slip),
        .locked     (locked),
        .error      (error),
        .err_count  (err_count),
        .word_count (word_count),
        .slip_count (slip_count)
    );

    axil_regs u_axil_regs (
        .CLK            (CLK),
        .rst            (rst),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .locked         (locked),
        .err_count      (err_count),
        .word_count     (word_count),
        .slip_count     (slip_count),
        .enable         (enable),
        .clear_pulse    (clear_pulse)
    );

endmodule

/* tb_serdes_test.sv */
`timescale 1ns/10ps
`include "serdes_test_cfg.svh"

module tb_serdes_test;

    localparam int W          = `SERDES_DATA_WIDTH;
    localparam int L          = `SERDES_LOCK_WORDS;
    localparam int NROWS      = 4;
    localparam int AXI_WAIT   = 32;                          // cycles a channel may stall
    localparam int LOCK_LIMIT = 2 * (W * (L + 2) * W);       // slips x words x cycles, doubled
    localparam int MAX_FLIPS  = 5;
    localparam int FLIP_WIN   = MAX_FLIPS * (2 * W + 32);    // widest flip window of any row
    localparam int ROW_BOUND  = 3 * LOCK_LIMIT + FLIP_WIN + 1000;
    localparam int RUN_LIMIT  = (NROWS + 1) * ROW_BOUND;     // rows plus the register checks
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // loop delay in bits, flips to inject, random bits in each flip gap
    localparam int STIM [NROWS][3] = '{'{1, 0, 3}, '{4, 3, 4}, '{9, 5, 5}, '{13, 1, 2}};

    logic        CLK = 1'b0;
    logic        rst;
    logic        ser_out;
    logic        ser_in = 1'b0;           // driven only by the loopback line
    logic        error;
    logic [3:0]  s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [3:0]  s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;

    logic [15:0] line = '0;               // serial history, newest bit in bit 0
    logic [15:0] line_next;
    logic [3:0]  tap;                     // loop delay minus one
    logic        flip_now;                // inverts one bit on its way back
    logic [31:0] rng;                     // galois lfsr for the flip gaps
    int          cycles = 0;
    int          value_errs = 0;
    int          other_errs = 0;

    serdes_test_top u_serdes_test_top (.*);

    always #5 CLK = ~CLK;  // 10 ns period

    always @(posedge CLK) begin
        cycles <= cycles + 1;
    end

    // loopback cable, a longer tap means a longer delay
    assign line_next = {line[14:0], ser_out};

    always @(posedge CLK) begin
        line   <= line_next;
        ser_in <= line_next[tap] ^ flip_now;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v   = (v << 1) | int'(rng[0]);  // one step per bit taken
            rng = galois_step(rng);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        value_errs++;
        $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("Error: %s", what);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int hold,
                             output logic [1:0] resp);
        int wait_n;
        wait_n = 0;
        @(posedge CLK);
        s_axil_awaddr  <= addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata   <= data;
        s_axil_wstrb   <= 4'hF;
        s_axil_wvalid  <= 1'b1;
        do begin
            @(posedge CLK);
            wait_n++;
        end while (!(s_axil_awready && s_axil_wready) && wait_n < AXI_WAIT);  // handshake edge
        if (!(s_axil_awready && s_axil_wready)) report_failure("write was never accepted");
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        repeat (hold) begin
            @(posedge CLK);
            if (!s_axil_bvalid) report_failure("bvalid was not held while bready was low");
        end
        s_axil_bready <= 1'b1;
        wait_n = 0;
        do begin
            @(posedge CLK);
            wait_n++;
        end while (!s_axil_bvalid && wait_n < AXI_WAIT);
        if (!s_axil_bvalid) report_failure("no write response came back");
        resp = s_axil_bresp;  // registered, stable at the transfer edge
        s_axil_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input int hold, output logic [31:0] data,
                            output logic [1:0] resp);
        int wait_n;
        wait_n = 0;
        @(posedge CLK);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        do begin
            @(posedge CLK);
            wait_n++;
        end while (!s_axil_arready && wait_n < AXI_WAIT);
        if (!s_axil_arready) report_failure("read address was never accepted");
        s_axil_arvalid <= 1'b0;
        repeat (hold) begin
            @(posedge CLK);
            if (!s_axil_rvalid) report_failure("rvalid was not held while rready was low");
        end
        s_axil_rready <= 1'b1;
        wait_n = 0;
        do begin
            @(posedge CLK);
            wait_n++;
        end while (!s_axil_rvalid && wait_n < AXI_WAIT);
        if (!s_axil_rvalid) report_failure("no read data came back");
        data = s_axil_rdata;
        resp = s_axil_rresp;
        s_axil_rready <= 1'b0;
    endtask

    // polls STATUS until the locked bit reads want or the lock bound runs out
    task automatic wait_status(input logic want, output logic ok);
        logic [31:0] d;
        logic [1:0]  r;
        int          start;
        start = cycles;
        ok    = 1'b0;
        while (!ok && (cycles - start) < LOCK_LIMIT) begin
            axi_read(`SERDES_ADDR_STATUS, 0, d, r);
            ok = (d[0] == want);
        end
    endtask

    initial begin : watchdog
        while (cycles < RUN_LIMIT) @(posedge CLK);
        $display("run stopped at the cycle limit of %0d, something never finished", RUN_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] first;
        logic [1:0]  resp;
        logic        ok;
        logic        quiet;
        logic        exp_err;
        int          gap;
        int          n_flips;
        rst = 1'b1;
        tap = 4'd0;
        flip_now = 1'b0;
        rng = 32'h367b;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        repeat (3) @(posedge CLK);
        rst <= 1'b0;
        for (int r = 0; r < NROWS; r++) begin
            n_flips = STIM[r][1];
            exp_err = (n_flips != 0);
            @(posedge CLK);
            tap <= 4'(STIM[r][0] - 1);  // line is idle here, so the jump is harmless
            axi_write(`SERDES_ADDR_CTRL, 32'h1, 0, resp);
            if (resp !== RESP_OKAY) report_mismatch("bresp", {30'b0, resp}, {30'b0, RESP_OKAY});
            wait_status(1'b1, ok);
            if (!ok) report_failure($sformatf("link did not lock at delay %0d", STIM[r][0]));
            axi_read(`SERDES_ADDR_WORDCNT, 0, first, resp);
            repeat (4 * W) @(posedge CLK);
            axi_read(`SERDES_ADDR_WORDCNT, 0, rd, resp);
            if (rd <= first) begin
                value_errs++;
                $display("Fail WORDCNT: 0x%08h did not rise above 0x%08h", rd, first);
            end
            axi_write(`SERDES_ADDR_CTRL, 32'h3, 0, resp);  // clear counters while locked
            for (int f = 0; f < n_flips; f++) begin
                take_bits(STIM[r][2], gap);
                repeat (2 * W + gap) @(posedge CLK);  // at least two words apart
                flip_now <= 1'b1;
                @(posedge CLK);
                flip_now <= 1'b0;
            end
            repeat (STIM[r][0] + 3 * W) @(posedge CLK);  // last flip reaches the counter
            axi_read(`SERDES_ADDR_ERRCNT, 0, rd, resp);
            if (rd !== 32'(n_flips)) report_mismatch("ERRCNT", rd, 32'(n_flips));
            if (error !== exp_err) report_mismatch("error", {31'b0, error}, {31'b0, exp_err});
            axi_write(`SERDES_ADDR_CTRL, 32'h0, 0, resp);
            repeat (2 * W) @(posedge CLK);  // the word in flight drains out
            quiet = 1'b1;
            repeat (4 * W) begin
                @(posedge CLK);
                if (ser_out !== 1'b0 && quiet) begin
                    report_mismatch("ser_out", {31'b0, ser_out}, 32'h0);
                    quiet = 1'b0;
                end
            end
            wait_status(1'b0, ok);
            if (!ok) report_failure("locked stayed high after the link was disabled");
            axi_write(`SERDES_ADDR_CTRL, 32'h2, 0, resp);  // clear with the link idle
            axi_read(`SERDES_ADDR_WORDCNT, 0, rd, resp);
            if (rd !== 32'h0) report_mismatch("WORDCNT", rd, 32'h0);
            axi_read(`SERDES_ADDR_STATUS, 0, rd, resp);
            if (rd !== 32'h0) report_mismatch("STATUS", rd, 32'h0);  // unlocked, no slips since
        end
        axi_write(`SERDES_ADDR_CTRL, 32'h3, 5, resp);  // response held back for 5 cycles
        if (resp !== RESP_OKAY) report_mismatch("bresp", {30'b0, resp}, {30'b0, RESP_OKAY});
        axi_read(`SERDES_ADDR_CTRL, 5, rd, resp);
        if (rd !== 32'h1) report_mismatch("CTRL", rd, 32'h1);
        if (resp !== RESP_OKAY) report_mismatch("rresp", {30'b0, resp}, {30'b0, RESP_OKAY});
        axi_write(`SERDES_ADDR_ERRCNT, 32'hFFFF_FFFF, 0, resp);
        if (resp !== RESP_OKAY) report_mismatch("bresp", {30'b0, resp}, {30'b0, RESP_OKAY});
        axi_read(`SERDES_ADDR_ERRCNT, 0, rd, resp);
        if (rd !== 32'h0) report_mismatch("ERRCNT", rd, 32'h0);  // just cleared and no flips since
        axi_write(4'h2, 32'h1, 0, resp);
        if (resp !== RESP_SLVERR) report_mismatch("bresp", {30'b0, resp}, {30'b0, RESP_SLVERR});
        axi_read(4'h2, 0, rd, resp);
        if (resp !== RESP_SLVERR) report_mismatch("rresp", {30'b0, resp}, {30'b0, RESP_SLVERR});
        if (rd !== 32'h0) report_mismatch("rdata", rd, 32'h0);
        axi_write(`SERDES_ADDR_CTRL, 32'h0, 0, resp);
        axi_read(`SERDES_ADDR_CTRL, 0, rd, resp);
        if (rd !== 32'h0) report_mismatch("CTRL", rd, 32'h0);
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
serdes_test_pkg.sv
prbs_gen.sv
word_serializer.sv
word_deserializer.sv
prbs_checker.sv
axil_regs.sv
serdes_test_top.sv
tb_serdes_test.sv

/* run_sim.sh */
#!/bin/sh
# builds the loopback testbench with verilator, runs it and checks the closing message
verilator --binary --timescale 1ns/10ps -f compile.f --top-module tb_serdes_test \
    -o tb_serdes_test || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/tb_serdes_test)
echo "$sim_out"
echo "$sim_out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
